//--- common/openadc_pkg.sv
package openadc_pkg;

   // data widths
   typedef logic [11:0] adc_sample_t;   // sample or threshold
   typedef logic [7:0]  reg_addr_t;
   typedef logic [7:0]  reg_data_t;
   typedef logic [7:0]  gain_t;         // pwm increment

   // panel led source select
   typedef enum logic [1:0] {
      LED_STATUS = 2'd0,
      LED_TIMER  = 2'd1,
      LED_FLASH  = 2'd2,
      LED_FREQ   = 2'd3
   } led_mode_t;

   // one-shot level trigger
   typedef enum logic {
      TRIG_IDLE    = 1'b0,
      TRIG_ALLOWED = 1'b1
   } trig_state_t;

   // register map
   localparam reg_addr_t ADDR_STATUS  = 8'h00;   // read only
   localparam reg_addr_t ADDR_GAIN    = 8'h01;
   localparam reg_addr_t ADDR_TRIG_LO = 8'h02;   // threshold 7:0
   localparam reg_addr_t ADDR_TRIG_HI = 8'h03;   // threshold 11:8
   localparam reg_addr_t ADDR_CONTROL = 8'h04;

   // control register fields
   localparam int CTRL_ARM_BIT    = 0;
   localparam int CTRL_SOURCE_BIT = 1;   // 1 = live adc
   localparam int CTRL_LED_LSB    = 2;

   // status register fields
   localparam int STAT_ARMED_BIT = 0;
   localparam int STAT_PLL_BIT   = 1;
   localparam int STAT_TRIG_BIT  = 2;

endpackage

//--- src/openadc_control.sv
`timescale 1ns/1ps

module openadc_control (
   input  logic                     clk_usb,
   input  logic                     reset,
   input  openadc_pkg::reg_addr_t   reg_address_i,
   input  openadc_pkg::reg_data_t   reg_datai_i,
   input  logic                     reg_write_i,
   input  logic                     reg_read_i,
   input  logic                     dut_trigger_i,
   input  logic                     pll_status_i,
   output openadc_pkg::reg_data_t   reg_datao_o,
   output logic                     armed_o,
   output logic                     data_source_live_o,
   output openadc_pkg::led_mode_t   led_mode_o,
   output openadc_pkg::adc_sample_t trigger_level_o,
   output logic                     amp_gain_o
);

   openadc_pkg::gain_t     gain_q;
   openadc_pkg::reg_data_t trig_lo_q;
   logic [3:0]             trig_hi_q;
   logic [3:0]             ctrl_q;      // arm, source, led mode
   openadc_pkg::reg_data_t status;
   logic [8:0]             pwm_acc;     // bit 8 is the carry

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         gain_q    <= '0;
         trig_lo_q <= '0;
         trig_hi_q <= '0;
         ctrl_q    <= '0;
      end else if (reg_write_i) begin
         case (reg_address_i)
            openadc_pkg::ADDR_GAIN:    gain_q    <= reg_datai_i;
            openadc_pkg::ADDR_TRIG_LO: trig_lo_q <= reg_datai_i;
            openadc_pkg::ADDR_TRIG_HI: trig_hi_q <= reg_datai_i[3:0];
            openadc_pkg::ADDR_CONTROL: ctrl_q    <= reg_datai_i[3:0];
            default: ;   // status and unmapped addresses ignore writes
         endcase
      end
   end

   always_comb begin
      status = '0;
      status[openadc_pkg::STAT_ARMED_BIT] = armed_o;
      status[openadc_pkg::STAT_PLL_BIT]   = pll_status_i;
      status[openadc_pkg::STAT_TRIG_BIT]  = dut_trigger_i;
   end

   // readback only while the host holds reg_read_i
   always_comb begin
      reg_datao_o = '0;
      if (reg_read_i) begin
         case (reg_address_i)
            openadc_pkg::ADDR_STATUS:  reg_datao_o = status;
            openadc_pkg::ADDR_GAIN:    reg_datao_o = gain_q;
            openadc_pkg::ADDR_TRIG_LO: reg_datao_o = trig_lo_q;
            openadc_pkg::ADDR_TRIG_HI: reg_datao_o = {4'b0, trig_hi_q};
            openadc_pkg::ADDR_CONTROL: reg_datao_o = {4'b0, ctrl_q};
            default:                   reg_datao_o = '0;
         endcase
      end
   end

   assign armed_o            = ctrl_q[openadc_pkg::CTRL_ARM_BIT];
   assign data_source_live_o = ctrl_q[openadc_pkg::CTRL_SOURCE_BIT];
   assign led_mode_o = openadc_pkg::led_mode_t'(ctrl_q[openadc_pkg::CTRL_LED_LSB +: 2]);
   assign trigger_level_o    = {trig_hi_q, trig_lo_q};

   // first-order pwm whose carry density is gain/256
   always_ff @(posedge clk_usb) begin
      if (reset)
         pwm_acc <= '0;
      else
         pwm_acc <= {1'b0, pwm_acc[7:0]} + {1'b0, gain_q};
   end

   assign amp_gain_o = pwm_acc[8];

   // host side of the bus never overlaps the two strobes
   property p_no_rw_overlap;
      @(posedge clk_usb) disable iff (reset)
         !(reg_write_i && reg_read_i);
   endproperty

   a_no_rw_overlap: assert property (p_no_rw_overlap)
      else $error("reg_write_i and reg_read_i high together");

endmodule

//--- capture/adc_sample_path.sv
`timescale 1ns/1ps

module adc_sample_path (
   input  logic                     clk_usb,
   input  logic                     reset,
   input  openadc_pkg::adc_sample_t adc_data_i,
   input  logic                     data_source_live_i,
   output openadc_pkg::adc_sample_t sample_o
);

   openadc_pkg::adc_sample_t test_count;   // free running ramp
   openadc_pkg::adc_sample_t stage1;
   openadc_pkg::adc_sample_t stage2;

   always_ff @(posedge clk_usb) begin
      if (reset)
         test_count <= '0;
      else
         test_count <= test_count + 1'b1;
   end

   // two stages keep the alignment the capture side expects
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         stage1 <= '0;
         stage2 <= '0;
      end else begin
         stage1 <= data_source_live_i ? adc_data_i : test_count;
         stage2 <= stage1;
      end
   end

   assign sample_o = stage2;

endmodule

//--- capture/adc_level_trigger.sv
`timescale 1ns/1ps

module adc_level_trigger (
   input  logic                     clk_usb,
   input  logic                     reset,
   input  openadc_pkg::adc_sample_t sample_i,
   input  openadc_pkg::adc_sample_t trigger_level_i,
   input  logic                     armed_i,
   output logic                     trigger_adc_o,
   output logic                     trigger_allowed_o
);

   openadc_pkg::trig_state_t state;
   logic                     armed_q;
   logic                     arm_rise;
   logic                     level_hit;
   logic                     fire;

   assign arm_rise = armed_i & ~armed_q;

   // threshold msb set looks above the level, clear looks below
   assign level_hit = trigger_level_i[11] ? (sample_i > trigger_level_i)
                                          : (sample_i < trigger_level_i);
   assign fire = (state == openadc_pkg::TRIG_ALLOWED) && level_hit;

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         state         <= openadc_pkg::TRIG_IDLE;
         armed_q       <= 1'b0;
         trigger_adc_o <= 1'b0;
      end else begin
         armed_q       <= armed_i;
         trigger_adc_o <= fire;
         if (fire)
            state <= openadc_pkg::TRIG_IDLE;      // one shot per arm edge
         else if (arm_rise)
            state <= openadc_pkg::TRIG_ALLOWED;
      end
   end

   assign trigger_allowed_o = (state == openadc_pkg::TRIG_ALLOWED);

   property p_single_pulse;
      @(posedge clk_usb) disable iff (reset)
         trigger_adc_o |=> !trigger_adc_o;
   endproperty

   a_single_pulse: assert property (p_single_pulse)
      else $error("trigger_adc_o high on two consecutive cycles");

endmodule

//--- src/heartbeat_leds.sv
`timescale 1ns/1ps

module heartbeat_leds #(
   parameter int p_timer_width = 26
) (
   input  logic                   clk_usb,
   input  logic                   reset,
   input  logic                   armed_i,
   input  logic                   trigger_allowed_i,
   input  openadc_pkg::led_mode_t led_mode_i,
   output logic                   freq_measure_o,
   output logic                   flash_pattern_o,
   output logic                   led_armed_o,
   output logic                   led_capture_o
);

   logic [p_timer_width-1:0] timer;
   logic                     freq_bit_q;   // previous value of the strobe bit
   logic                     freq_bit;
   logic                     blink_bit;

   assign freq_bit  = timer[p_timer_width-4];
   assign blink_bit = timer[p_timer_width-2];

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         timer          <= '0;
         freq_bit_q     <= 1'b0;
         freq_measure_o <= 1'b0;
      end else begin
         timer          <= timer + 1'b1;
         freq_bit_q     <= freq_bit;
         freq_measure_o <= freq_bit & ~freq_bit_q;   // rising edge only
      end
   end

   // pattern only moves in the upper half of the timer period
   always_ff @(posedge clk_usb) begin
      if (reset)
         flash_pattern_o <= 1'b0;
      else if (timer[p_timer_width-1])
         flash_pattern_o <= ~timer[p_timer_width-3];
   end

   always_comb begin
      case (led_mode_i)
         openadc_pkg::LED_TIMER: begin
            led_armed_o   = blink_bit;
            led_capture_o = blink_bit;
         end
         openadc_pkg::LED_FLASH: begin
            led_armed_o   = flash_pattern_o;
            led_capture_o = flash_pattern_o;
         end
         openadc_pkg::LED_FREQ: begin
            led_armed_o   = freq_measure_o;
            led_capture_o = ~blink_bit;
         end
         default: begin   // status
            led_armed_o   = armed_i;
            led_capture_o = trigger_allowed_i;
         end
      endcase
   end

endmodule

//--- src/openadc_top.sv
`timescale 1ns/1ps

module openadc_top #(
   parameter int p_timer_width = 26
) (
   input  logic                    clk_usb,
   input  logic                    reset,
   input  openadc_pkg::adc_sample_t adc_data_i,
   input  logic                    dut_trigger_i,
   input  logic                    pll_status_i,
   input  openadc_pkg::reg_addr_t  reg_address_i,
   input  openadc_pkg::reg_data_t  reg_datai_i,
   input  logic                    reg_write_i,
   input  logic                    reg_read_i,
   output openadc_pkg::reg_data_t  reg_datao_o,
   output logic                    trigger_adc_o,
   output logic                    amp_gain_o,
   output logic                    freq_measure_o,
   output logic                    flash_pattern_o,
   output logic                    led_armed_o,
   output logic                    led_capture_o
);

   logic                      armed;
   logic                      data_source_live;
   openadc_pkg::led_mode_t    led_mode;
   openadc_pkg::adc_sample_t  trigger_level;
   openadc_pkg::adc_sample_t  sample;
   logic                      trigger_allowed;   // capture indication for the leds

   openadc_control openadc_control_inst (
      .clk_usb            (clk_usb),
      .reset              (reset),
      .reg_address_i      (reg_address_i),
      .reg_datai_i        (reg_datai_i),
      .reg_write_i        (reg_write_i),
      .reg_read_i         (reg_read_i),
      .dut_trigger_i      (dut_trigger_i),
      .pll_status_i       (pll_status_i),
      .reg_datao_o        (reg_datao_o),
      .armed_o            (armed),
      .data_source_live_o (data_source_live),
      .led_mode_o         (led_mode),
      .trigger_level_o    (trigger_level),
      .amp_gain_o         (amp_gain_o)
   );

   adc_sample_path adc_sample_path_inst (
      .clk_usb            (clk_usb),
      .reset              (reset),
      .adc_data_i         (adc_data_i),
      .data_source_live_i (data_source_live),
      .sample_o           (sample)
   );

   adc_level_trigger adc_level_trigger_inst (
      .clk_usb           (clk_usb),
      .reset             (reset),
      .sample_i          (sample),
      .trigger_level_i   (trigger_level),
      .armed_i           (armed),
      .trigger_adc_o     (trigger_adc_o),
      .trigger_allowed_o (trigger_allowed)
   );

   heartbeat_leds #(
      .p_timer_width (p_timer_width)
   ) heartbeat_leds_inst (
      .clk_usb           (clk_usb),
      .reset             (reset),
      .armed_i           (armed),
      .trigger_allowed_i (trigger_allowed),
      .led_mode_i        (led_mode),
      .freq_measure_o    (freq_measure_o),
      .flash_pattern_o   (flash_pattern_o),
      .led_armed_o       (led_armed_o),
      .led_capture_o     (led_capture_o)
   );

endmodule

//--- dv/clock_gen.sv
`timescale 1ns/1ps

module clock_gen #(
   parameter real p_period_ns    = 8.0,
   parameter int  p_reset_cycles = 10
) (
   output logic clk_usb,
   output logic reset
);

   initial begin
      clk_usb = 1'b0;
      forever #(p_period_ns / 2.0) clk_usb = ~clk_usb;
   end

   initial begin
      reset = 1'b1;
      repeat (p_reset_cycles) @(posedge clk_usb);
      reset <= 1'b0;   // released on a rising edge
   end

endmodule

//--- dv/openadc_checker.sv
`timescale 1ns/1ps

module openadc_checker #(
   parameter int p_timer_width = 26
) (
   input  logic                     clk_usb,
   input  logic                     reset,
   input  openadc_pkg::adc_sample_t adc_data_i,
   input  logic                     dut_trigger_i,
   input  logic                     pll_status_i,
   input  openadc_pkg::reg_addr_t   reg_address_i,
   input  openadc_pkg::reg_data_t   reg_datai_i,
   input  logic                     reg_write_i,
   input  logic                     reg_read_i,
   input  openadc_pkg::reg_data_t   reg_datao_o,
   input  logic                     trigger_adc_o,
   input  logic                     amp_gain_o,
   input  logic                     freq_measure_o,
   input  logic                     flash_pattern_o,
   input  logic                     led_armed_o,
   input  logic                     led_capture_o,
   output int                       errors_o,
   output int                       trig_pulses_o
);

   openadc_pkg::reg_data_t   gain;
   openadc_pkg::reg_data_t   trig_lo;
   logic [3:0]               trig_hi;
   logic [3:0]               ctrl;
   openadc_pkg::reg_data_t   gain_used;   // gain behind the visible carry
   openadc_pkg::reg_data_t   win_gain;
   logic [8:0]               win_len;
   logic [8:0]               win_ones;
   openadc_pkg::adc_sample_t count;    // ramp since reset
   openadc_pkg::adc_sample_t stage1;
   openadc_pkg::adc_sample_t stage2;
   openadc_pkg::adc_sample_t thr;
   logic                     allowed;
   logic                     armed_q;
   logic                     hit;
   logic                     trig_exp;
   logic [p_timer_width-1:0] timer;
   logic                     freq_q;
   logic                     freq_exp;
   logic                     flash_exp;
   logic                     blink;
   openadc_pkg::reg_data_t   datao_exp;
   logic                     led_a_exp;
   logic                     led_c_exp;
   int                       errors = 0;
   int                       pulses = 0;

   assign errors_o      = errors;
   assign trig_pulses_o = pulses;
   assign thr   = {trig_hi, trig_lo};
   assign hit   = thr[11] ? (stage2 > thr) : (stage2 < thr);
   assign blink = timer[p_timer_width-2];

   always_comb begin
      datao_exp = '0;
      if (reg_read_i) begin
         case (reg_address_i)
            openadc_pkg::ADDR_STATUS:  datao_exp = {5'b0, dut_trigger_i, pll_status_i, ctrl[0]};
            openadc_pkg::ADDR_GAIN:    datao_exp = gain;
            openadc_pkg::ADDR_TRIG_LO: datao_exp = trig_lo;
            openadc_pkg::ADDR_TRIG_HI: datao_exp = {4'b0, trig_hi};
            openadc_pkg::ADDR_CONTROL: datao_exp = {4'b0, ctrl};
            default:                   datao_exp = '0;
         endcase
      end
      case (ctrl[3:2])
         openadc_pkg::LED_STATUS: begin
            led_a_exp = ctrl[0];
            led_c_exp = allowed;
         end
         openadc_pkg::LED_TIMER: begin
            led_a_exp = blink;
            led_c_exp = blink;
         end
         openadc_pkg::LED_FLASH: begin
            led_a_exp = flash_exp;
            led_c_exp = flash_exp;
         end
         default: begin
            led_a_exp = freq_exp;
            led_c_exp = ~blink;
         end
      endcase
   end

   task automatic compare_value(input string name, input logic [7:0] expected,
                                input logic [7:0] actual);
      if (actual !== expected) begin
         errors++;
         $display("FAILED %s at %0t: expected %h, got %h", name, $time, expected, actual);
      end
   endtask

   // outputs checked mid-cycle before the model steps on the same inputs
   always @(negedge clk_usb) begin
      if (reset) begin
         gain      <= '0;
         trig_lo   <= '0;
         trig_hi   <= '0;
         ctrl      <= '0;
         gain_used <= '0;
         win_gain  <= '0;
         win_len   <= '0;
         win_ones  <= '0;
         count     <= '0;
         stage1    <= '0;
         stage2    <= '0;
         allowed   <= 1'b0;
         armed_q   <= 1'b0;
         trig_exp  <= 1'b0;
         timer     <= '0;
         freq_q    <= 1'b0;
         freq_exp  <= 1'b0;
         flash_exp <= 1'b0;
      end else begin
         compare_value("reg_datao_o", datao_exp, reg_datao_o);
         compare_value("freq_measure_o", 8'(freq_exp), 8'(freq_measure_o));
         compare_value("flash_pattern_o", 8'(flash_exp), 8'(flash_pattern_o));
         compare_value("led_armed_o", 8'(led_a_exp), 8'(led_armed_o));
         compare_value("led_capture_o", 8'(led_c_exp), 8'(led_capture_o));
         if (trig_exp === 1'b1 && trigger_adc_o !== 1'b1) begin
            errors++;
            $display("missing trigger pulse at %0t for threshold %h", $time, thr);
         end else begin
            compare_value("trigger_adc_o", 8'(trig_exp), 8'(trigger_adc_o));
         end
         if (trigger_adc_o === 1'b1)
            pulses++;

         // 256 cycles of one gain give exactly gain carries
         if (win_len == 9'd0 || gain_used !== win_gain) begin
            win_gain <= gain_used;
            win_len  <= 9'd1;
            win_ones <= 9'(amp_gain_o);
         end else if (win_len == 9'd255) begin
            if (win_ones + 9'(amp_gain_o) !== {1'b0, win_gain}) begin
               errors++;
               $display("FAILED amp_gain_o high count at %0t: expected %h, got %h",
                        $time, win_gain, win_ones + 9'(amp_gain_o));
            end
            win_len <= 9'd0;
         end else begin
            win_len  <= win_len + 9'd1;
            win_ones <= win_ones + 9'(amp_gain_o);
         end
         gain_used <= gain;

         if (reg_write_i) begin
            case (reg_address_i)
               openadc_pkg::ADDR_GAIN:    gain    <= reg_datai_i;
               openadc_pkg::ADDR_TRIG_LO: trig_lo <= reg_datai_i;
               openadc_pkg::ADDR_TRIG_HI: trig_hi <= reg_datai_i[3:0];
               openadc_pkg::ADDR_CONTROL: ctrl    <= reg_datai_i[3:0];
               default: ;
            endcase
         end
         count  <= count + 12'd1;
         stage1 <= ctrl[1] ? adc_data_i : count;
         stage2 <= stage1;
         trig_exp <= allowed && hit;
         armed_q  <= ctrl[0];
         if (allowed && hit)
            allowed <= 1'b0;
         else if (ctrl[0] && !armed_q)
            allowed <= 1'b1;
         timer    <= timer + 1'b1;
         freq_q   <= timer[p_timer_width-4];
         freq_exp <= timer[p_timer_width-4] && !freq_q;
         if (timer[p_timer_width-1])
            flash_exp <= ~timer[p_timer_width-3];
      end
   end

endmodule

//--- dv/tb_openadc.sv
`timescale 1ns/1ps

module tb_openadc;

   localparam int TIMER_WIDTH  = 10;
   localparam int ROUNDS       = 40;
   localparam int IDLE_CYCLES  = 320;
   localparam int ROUND_CYCLES = 2 * 11 + IDLE_CYCLES;   // eleven bus accesses
   localparam int TOTAL_CYCLES = 10 + ROUNDS * ROUND_CYCLES;
   localparam int TIMEOUT_NS   = 2 * TOTAL_CYCLES * 8;

   logic                     clk_usb;
   logic                     reset;
   openadc_pkg::adc_sample_t adc_data_i;
   logic                     dut_trigger_i;
   logic                     pll_status_i;
   openadc_pkg::reg_addr_t   reg_address_i;
   openadc_pkg::reg_data_t   reg_datai_i;
   logic                     reg_write_i;
   logic                     reg_read_i;
   openadc_pkg::reg_data_t   reg_datao_o;
   logic                     trigger_adc_o;
   logic                     amp_gain_o;
   logic                     freq_measure_o;
   logic                     flash_pattern_o;
   logic                     led_armed_o;
   logic                     led_capture_o;
   int                       checker_errors;
   int                       trig_pulses;
   int                       tb_errors;

   clock_gen clock_gen_inst (.clk_usb(clk_usb), .reset(reset));

   openadc_top #(.p_timer_width(TIMER_WIDTH)) openadc_top_inst (.*);

   openadc_checker #(.p_timer_width(TIMER_WIDTH)) openadc_checker_inst (
      .errors_o      (checker_errors),
      .trig_pulses_o (trig_pulses),
      .*
   );

   // fresh adc data and status pins every cycle
   task automatic drive_pins();
      forever begin
         @(posedge clk_usb);
         adc_data_i    <= 12'($urandom);
         dut_trigger_i <= 1'($urandom);
         pll_status_i  <= 1'($urandom);
      end
   endtask

   task automatic write_reg(input openadc_pkg::reg_addr_t addr,
                            input openadc_pkg::reg_data_t data);
      @(posedge clk_usb);
      reg_address_i <= addr;
      reg_datai_i   <= data;
      reg_write_i   <= 1'b1;
      @(posedge clk_usb);
      reg_write_i   <= 1'b0;
   endtask

   task automatic read_reg(input openadc_pkg::reg_addr_t addr);
      @(posedge clk_usb);
      reg_address_i <= addr;
      reg_read_i    <= 1'b1;
      @(posedge clk_usb);
      reg_read_i    <= 1'b0;
   endtask

   initial begin
      openadc_pkg::reg_data_t ctrl;
      void'($urandom(32'h9e4b2266));
      adc_data_i    = '0;
      dut_trigger_i = 1'b0;
      pll_status_i  = 1'b0;
      reg_address_i = '0;
      reg_datai_i   = '0;
      reg_write_i   = 1'b0;
      reg_read_i    = 1'b0;
      tb_errors     = 0;
      fork
         drive_pins();
      join_none
      wait (reset === 1'b0);
      for (int r = 0; r < ROUNDS; r++) begin
         ctrl = 8'($urandom) & 8'hfe;   // random source and led mode with arm cleared
         write_reg(openadc_pkg::ADDR_GAIN, 8'($urandom));
         write_reg(openadc_pkg::ADDR_TRIG_LO, 8'($urandom));
         write_reg(openadc_pkg::ADDR_TRIG_HI, 8'($urandom));
         write_reg(openadc_pkg::ADDR_CONTROL, ctrl);
         for (int a = 0; a < 6; a++)
            read_reg(8'(a));   // address 5 is unmapped
         write_reg(openadc_pkg::ADDR_CONTROL, ctrl | 8'h01);
         repeat (IDLE_CYCLES) @(posedge clk_usb);
      end
      @(negedge clk_usb);
      @(posedge clk_usb);
      if (trig_pulses == 0) begin
         tb_errors++;
         $display("trigger_adc_o never pulsed during the whole run");
      end
      $display("run complete: %0d errors (%0d from the checker, %0d from the testbench)",
               checker_errors + tb_errors, checker_errors, tb_errors);
      if (checker_errors + tb_errors == 0)
         $display("Simulation passed");
      else
         $display("Simulation failed");
      $finish;
   end

   initial begin
      #(TIMEOUT_NS);
      $display("watchdog expired after %0d ns before the stimulus finished", TIMEOUT_NS);
      $display("Simulation failed");
      $finish;
   end

endmodule

//--- sources.f
common/openadc_pkg.sv
src/openadc_control.sv
capture/adc_sample_path.sv
capture/adc_level_trigger.sv
src/heartbeat_leds.sv
src/openadc_top.sv
dv/clock_gen.sv
dv/openadc_checker.sv
dv/tb_openadc.sv

//--- run_sim.sh
#!/bin/sh
# build and run the openadc testbench with verilator

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert --top-module tb_openadc -f sources.f
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/Vtb_openadc > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "Simulation failed" "$log"; then
   exit 1
fi
exit 0
